// File: include/rsqrt_seed_table.svh
`ifndef RSQRT_SEED_TABLE_SVH
`define RSQRT_SEED_TABLE_SVH

// entry k is 2^27 / sqrt(2 * mid_k), mid_k = (k + 0.5) / 16
// only k = 16..63 occur for a normalized mantissa
function automatic recip_t rsqrt_seed_lookup(input logic [SEED_BITS-1:0] idx);
   case (idx)
      6'd16: return 28'd93457226;
      6'd17: return 28'd90747740;
      6'd18: return 28'd88261050;
      6'd19: return 28'd85968120;
      6'd20: return 28'd83845200;
      6'd21: return 28'd81871970;
      6'd22: return 28'd80032040;
      6'd23: return 28'd78310680;
      6'd24: return 28'd76695845;
      6'd25: return 28'd75176960;
      6'd26: return 28'd73744900;
      6'd27: return 28'd72391700;
      6'd28: return 28'd71110320;
      6'd29: return 28'd69894650;
      6'd30: return 28'd68739270;
      6'd31: return 28'd67639380;
      6'd32: return 28'd66590640;
      6'd33: return 28'd65589210;
      6'd34: return 28'd64631650;
      6'd35: return 28'd63714900;
      6'd36: return 28'd62836010;
      6'd37: return 28'd61992570;
      6'd38: return 28'd61182100;
      6'd39: return 28'd60402770;
      6'd40: return 28'd59652324;
      6'd41: return 28'd58929250;
      6'd42: return 28'd58231890;
      6'd43: return 28'd57558560;
      6'd44: return 28'd56908200;
      6'd45: return 28'd56279360;
      6'd46: return 28'd55670900;
      6'd47: return 28'd55081860;
      6'd48: return 28'd54511010;
      6'd49: return 28'd53957590;
      6'd50: return 28'd53420590;
      6'd51: return 28'd52899500;
      6'd52: return 28'd52393280;
      6'd53: return 28'd51901280;
      6'd54: return 28'd51422870;
      6'd55: return 28'd50957550;
      6'd56: return 28'd50504550;
      6'd57: return 28'd50063450;
      6'd58: return 28'd49633740;
      6'd59: return 28'd49214860;
      6'd60: return 28'd48806447;
      6'd61: return 28'd48408000;
      6'd62: return 28'd48019220;
      6'd63: return 28'd47639600;
      default: return 28'd0;   // zero operand, overridden later
   endcase
endfunction

`endif

// File: src/fsqrt_pkg.sv
package fsqrt_pkg;

   // single precision fields
   typedef logic [31:0] fp_word_t;
   typedef logic [7:0]  exp_t;
   typedef logic [22:0] mant_t;

   // mantissa in [1,4), 2 integer bits and 23 fraction bits
   typedef logic [24:0] norm_mant_t;

   // reciprocal root estimate, 1 integer bit and 27 fraction bits
   typedef logic [27:0] recip_t;

   // top mantissa bits that address the seed table
   localparam int SEED_BITS = 6;

   // in_valid to out_valid
   localparam int LATENCY = 7;

   localparam exp_t EXP_MAX       = 8'd255;
   localparam exp_t EXP_HALF_BIAS = 8'd64;   // added to the halved exponent

endpackage

// File: src/sqrt_normalize.sv
`timescale 1ns/1ns
`default_nettype none

module sqrt_normalize (
   input  logic                 clk,
   input  logic                 reset,
   input  fsqrt_pkg::fp_word_t  x,
   input  logic                 in_valid,
   output fsqrt_pkg::norm_mant_t mant,
   output fsqrt_pkg::exp_t      half_exp,
   output logic                 valid
);
   import fsqrt_pkg::*;

   exp_t       e;
   mant_t      m;
   logic [4:0] lead;      // leading one of a denormal fraction
   logic [4:0] k;         // shift pairs for a denormal
   norm_mant_t mant_next;
   exp_t       hexp_next;

   assign e = x[30:23];
   assign m = x[22:0];

   always_comb begin
      lead = '0;
      for (int i = 0; i < 23; i++) begin
         if (m[i])
            lead = i[4:0];
      end
      k = (5'd23 - lead) >> 1;

      if (|e) begin
         // odd exponent keeps the mantissa one bit higher, in [2,4)
         mant_next = e[0] ? {1'b1, m, 1'b0} : {2'b01, m};
         hexp_next = {1'b0, e[7:1]} + EXP_HALF_BIAS;
      end else begin
         // even shift so the exponent stays even
         mant_next = norm_mant_t'({2'b00, m}) << ({k, 1'b0} + 6'd1);
         hexp_next = EXP_HALF_BIAS - {3'b000, k};
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= in_valid;
   end

   always_ff @(posedge clk) begin
      mant     <= mant_next;
      half_exp <= hexp_next;
   end

endmodule

`default_nettype wire

// File: src/rsqrt_seed.sv
`timescale 1ns/1ns
`default_nettype none

module rsqrt_seed (
   input  logic                  clk,
   input  logic                  reset,
   input  fsqrt_pkg::norm_mant_t mant,
   input  fsqrt_pkg::exp_t       half_exp,
   input  logic                  valid_in,
   output fsqrt_pkg::norm_mant_t mant_out,
   output fsqrt_pkg::exp_t       half_exp_out,
   output fsqrt_pkg::recip_t     seed,
   output logic                  valid
);
   import fsqrt_pkg::*;

`include "rsqrt_seed_table.svh"

   logic [SEED_BITS-1:0] index;

   assign index = mant[24 -: SEED_BITS];   // interval of 1/16

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= valid_in;
   end

   always_ff @(posedge clk) begin
      seed         <= rsqrt_seed_lookup(index);
      mant_out     <= mant;
      half_exp_out <= half_exp;
   end

endmodule

`default_nettype wire

// File: src/newton_step.sv
`timescale 1ns/1ns
`default_nettype none

module newton_step (
   input  logic                  clk,
   input  logic                  reset,
   input  fsqrt_pkg::norm_mant_t mant,
   input  fsqrt_pkg::exp_t       half_exp,
   input  fsqrt_pkg::recip_t     estimate,
   input  logic                  valid_in,
   output fsqrt_pkg::norm_mant_t mant_out,
   output fsqrt_pkg::exp_t       half_exp_out,
   output fsqrt_pkg::recip_t     refined,
   output logic                  valid
);
   import fsqrt_pkg::*;

   // r' = r * (3 - 2*m*r^2) / 2, root of 2*m
   logic [52:0]  k;       // m * r, 50 fraction bits
   logic [55:0]  l;       // r * r, 54 fraction bits
   logic [108:0] mr3;     // 104 fraction bits
   logic [29:0]  n;       // 3 * r
   logic [110:0] p;       // (3r - 2*m*r^3), 105 fraction bits
   recip_t       r_next;

   assign k   = mant * estimate;
   assign l   = estimate * estimate;
   assign mr3 = k * l;
   assign n   = {2'b00, estimate} + {1'b0, estimate, 1'b0};
   assign p   = {3'b000, n, 78'b0} - {mr3, 2'b00};

   // nearest, ties to even
   assign r_next = (p[78] && (|p[77:0] || p[79])) ? p[106:79] + 28'd1 : p[106:79];

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= valid_in;
   end

   always_ff @(posedge clk) begin
      refined      <= r_next;
      mant_out     <= mant;
      half_exp_out <= half_exp;
   end

endmodule

`default_nettype wire

// File: src/root_round.sv
`timescale 1ns/1ns
`default_nettype none

module root_round (
   input  logic                clk,
   input  logic                reset,
   input  fsqrt_pkg::recip_t   estimate,
   input  fsqrt_pkg::exp_t     half_exp,
   input  logic                valid_in,
   output fsqrt_pkg::fp_word_t recip_word,
   output logic                valid
);
   import fsqrt_pkg::*;

   logic [24:0] mye;     // rounded 24-bit mantissa plus carry
   exp_t        eye;
   exp_t        ey;
   mant_t       my;

   always_comb begin
      if (estimate[27]) begin
         mye = {1'b0, estimate[27:4]} + 25'(estimate[3]);
         eye = EXP_MAX - half_exp;
      end else if (estimate[26]) begin
         mye = {1'b0, estimate[26:3]} + 25'(estimate[2]);
         eye = (EXP_MAX - 8'd1) - half_exp;
      end else if (estimate[25]) begin
         mye = {1'b0, estimate[25:2]} + 25'(estimate[1]);
         eye = (EXP_MAX - 8'd2) - half_exp;
      end else begin
         mye = {1'b0, estimate[24:1]} + 25'(estimate[0]);
         eye = (EXP_MAX - 8'd3) - half_exp;
      end
   end

   // carry out of the rounding bumps the exponent
   assign my = mye[24] ? 23'b0 : mye[22:0];
   assign ey = mye[24] ? eye + 8'd1 : eye;

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= valid_in;
   end

   always_ff @(posedge clk)
      recip_word <= {1'b0, ey, my};   // always positive

endmodule

`default_nettype wire

// File: src/fp_mul.sv
`timescale 1ns/1ns
`default_nettype none

module fp_mul (
   input  logic                clk,
   input  logic                reset,
   input  fsqrt_pkg::fp_word_t a,
   input  fsqrt_pkg::fp_word_t b,
   input  logic                valid_in,
   output fsqrt_pkg::fp_word_t product,
   output logic                valid
);
   import fsqrt_pkg::*;

   logic [23:0] ma, mb;
   logic [47:0] p;
   logic [47:0] ps;       // leading one moved to bit 47
   logic [5:0]  lead;
   logic [24:0] rounded;
   logic [9:0]  exp_sum;
   exp_t        ea;
   fp_word_t    prod_next;

   // denormal a enters with no hidden bit and exponent 1
   assign ma = {|a[30:23], a[22:0]};
   assign mb = {|b[30:23], b[22:0]};
   assign ea = a[30:23] | {7'b0, ~|a[30:23]};
   assign p  = ma * mb;

   always_comb begin
      lead = '0;
      for (int i = 0; i < 48; i++) begin
         if (p[i])
            lead = i[5:0];
      end
      ps      = p << (6'd47 - lead);
      rounded = {1'b0, ps[47:24]} + 25'(ps[23]);   // half up
      exp_sum = {2'b00, ea} + {2'b00, b[30:23]} + {4'b0000, lead} - 10'd173;
      prod_next = {a[31] ^ b[31],
                   exp_sum[7:0] + {7'b0, rounded[24]},
                   rounded[24] ? 23'b0 : rounded[22:0]};
   end

   always_ff @(posedge clk) begin
      if (reset)
         valid <= 1'b0;
      else
         valid <= valid_in;
   end

   always_ff @(posedge clk)
      product <= prod_next;

endmodule

`default_nettype wire

// File: src/result_select.sv
`timescale 1ns/1ns
`default_nettype none

module result_select (
   input  logic                clk,
   input  logic                reset,
   input  fsqrt_pkg::fp_word_t x,
   input  fsqrt_pkg::fp_word_t product,
   input  logic                valid_in,
   output fsqrt_pkg::fp_word_t x_late,
   output fsqrt_pkg::fp_word_t y,
   output logic                exception,
   output logic                out_valid
);
   import fsqrt_pkg::*;

   fp_word_t x_dly [1:6];    // operand follows the datapath
   fp_word_t xs;
   fp_word_t y_next;
   logic     is_nan, is_zero, is_neg;

   assign x_late = x_dly[5];   // lines up with recip_word
   assign xs     = x_dly[6];

   assign is_nan  = (xs[30:23] == EXP_MAX) && |xs[22:0];
   assign is_zero = ~|xs[30:0];
   assign is_neg  = xs[31] && !is_zero;

   always_comb begin
      if (is_nan)
         y_next = {xs[31], EXP_MAX, 1'b1, xs[21:0]};   // quiet, payload kept
      else if (xs == {1'b0, EXP_MAX, 23'b0})
         y_next = xs;                                 // +inf
      else if (is_zero)
         y_next = xs;                                 // +0 or -0
      else if (is_neg)
         y_next = {1'b1, EXP_MAX, 1'b1, 22'b0};
      else
         y_next = product;
   end

   always_ff @(posedge clk) begin
      x_dly[1] <= x;
      for (int i = 2; i <= 6; i++)
         x_dly[i] <= x_dly[i-1];
   end

   always_ff @(posedge clk) begin
      if (reset)
         out_valid <= 1'b0;
      else
         out_valid <= valid_in;
   end

   always_ff @(posedge clk) begin
      y         <= y_next;
      exception <= is_nan || is_neg;
   end

endmodule

`default_nettype wire

// File: src/fsqrt.sv
`timescale 1ns/1ns
`default_nettype none

module fsqrt (
   input  logic               clk,
   input  logic               reset,
   input  fsqrt_pkg::fp_word_t x,
   input  logic               in_valid,
   output fsqrt_pkg::fp_word_t y,
   output logic               exception,
   output logic               out_valid
);
   import fsqrt_pkg::*;

   norm_mant_t mant_n, mant_s, mant_1;
   exp_t       hexp_n, hexp_s, hexp_1, hexp_2;
   recip_t     seed, est_1, est_2;
   fp_word_t   recip_word, x_late, product;
   logic       valid_n, valid_s, valid_1, valid_2, valid_r, valid_m;

   sqrt_normalize i_normalize (
      .clk(clk), .reset(reset), .x(x), .in_valid(in_valid),
      .mant(mant_n), .half_exp(hexp_n), .valid(valid_n));

   rsqrt_seed i_seed (
      .clk(clk), .reset(reset), .mant(mant_n), .half_exp(hexp_n), .valid_in(valid_n),
      .mant_out(mant_s), .half_exp_out(hexp_s), .seed(seed), .valid(valid_s));

   // two refinements of the seed
   newton_step i_newton_1 (
      .clk(clk), .reset(reset), .mant(mant_s), .half_exp(hexp_s), .estimate(seed),
      .valid_in(valid_s), .mant_out(mant_1), .half_exp_out(hexp_1), .refined(est_1),
      .valid(valid_1));

   newton_step i_newton_2 (
      .clk(clk), .reset(reset), .mant(mant_1), .half_exp(hexp_1), .estimate(est_1),
      .valid_in(valid_1), .mant_out(), .half_exp_out(hexp_2), .refined(est_2),
      .valid(valid_2));

   root_round i_round (
      .clk(clk), .reset(reset), .estimate(est_2), .half_exp(hexp_2), .valid_in(valid_2),
      .recip_word(recip_word), .valid(valid_r));

   fp_mul i_mul (
      .clk(clk), .reset(reset), .a(x_late), .b(recip_word), .valid_in(valid_r),
      .product(product), .valid(valid_m));

   result_select i_select (
      .clk(clk), .reset(reset), .x(x), .product(product), .valid_in(valid_m),
      .x_late(x_late), .y(y), .exception(exception), .out_valid(out_valid));

endmodule

`default_nettype wire

// File: bench/fsqrt_props.sv
`timescale 1ns/1ns

module fsqrt_props (
   input logic                clk,
   input logic                reset,
   input fsqrt_pkg::fp_word_t x,
   input logic                in_valid,
   input fsqrt_pkg::fp_word_t y,
   input logic                exception,
   input logic                out_valid
);
   import fsqrt_pkg::*;

   // each operand leaves exactly LATENCY cycles after it entered
   assert property (@(posedge clk) disable iff (reset)
      $past(in_valid, LATENCY) |-> out_valid)
      else $error("out_valid missing %0d cycles after in_valid", LATENCY);

   // no result without an operand, also right after reset
   assert property (@(posedge clk) disable iff (reset)
      out_valid |-> $past(in_valid, LATENCY))
      else $error("out_valid high with no in_valid %0d cycles before", LATENCY);

   assert property (@(posedge clk) reset |=> !out_valid)
      else $error("out_valid high after a reset cycle");

   // flagged results are quiet NaNs
   assert property (@(posedge clk) out_valid && exception |-> (&y[30:23]) && y[22])
      else $error("exception raised but y is not a quiet NaN");

   assert property (@(posedge clk) out_valid && !exception |-> !((&y[30:23]) && (|y[22:0])))
      else $error("NaN result without exception");

   // flag follows the operand class: NaN, or negative and not zero
   assert property (@(posedge clk) disable iff (reset)
      out_valid |-> exception == (((&$past(x[30:23], LATENCY)) && (|$past(x[22:0], LATENCY)))
                                  || ($past(x[31], LATENCY) && (|$past(x[30:0], LATENCY)))))
      else $error("exception does not match the operand class");

   // only -0 may come out negative without a flag
   assert property (@(posedge clk) out_valid && !exception && y[31] |-> y[30:0] == 31'd0)
      else $error("negative result without exception");

endmodule

// File: bench/fsqrt_tb.sv
`timescale 1ns/1ns

module fsqrt_tb;
   import fsqrt_pkg::*;

   logic     clk;
   logic     reset;
   fp_word_t x;
   logic     in_valid;
   fp_word_t y;
   logic     exception;
   logic     out_valid;

   fp_word_t    want_y_q [$];     // expected results in issue order
   logic        want_exc_q [$];
   logic        exact_q [$];      // low means 2 ulp tolerance
   fp_word_t    want_y;
   logic        want_exc;
   logic        want_exact;
   logic [15:0] lfsr_state;
   int          mismatches;
   int          other_errors;
   int          checked;

   fsqrt i_fsqrt (.clk(clk), .reset(reset), .x(x), .in_valid(in_valid), .y(y),
                  .exception(exception), .out_valid(out_valid));

   bind fsqrt fsqrt_props i_props (.clk(clk), .reset(reset), .x(x), .in_valid(in_valid),
                                   .y(y), .exception(exception), .out_valid(out_valid));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic real pow2(input int n);
      real v;
      v = 1.0;
      for (int i = 0; i < n; i++)
         v = v * 2.0;
      for (int i = 0; i > n; i--)
         v = v / 2.0;
      return v;
   endfunction

   // magnitude of a finite word
   function automatic real to_real(input fp_word_t w);
      if (w[30:23] == 8'd0)
         return real'(w[22:0]) * pow2(-149);
      return real'({1'b1, w[22:0]}) * pow2(int'(w[30:23]) - 150);
   endfunction

   // nearest single for a positive real in the normal range
   function automatic fp_word_t round_to_single(input real r);
      real    v;
      int     e;
      longint m;
      v = r;
      e = 0;
      while (v >= 2.0) begin
         v = v / 2.0;
         e++;
      end
      while (v < 1.0) begin
         v = v * 2.0;
         e--;
      end
      m = longint'(v * 8388608.0);
      if (m == 64'd16777216) begin
         m = 64'd8388608;
         e++;
      end
      return {1'b0, 8'(e + 127), m[22:0]};
   endfunction

   function automatic logic [31:0] ulp_gap(input fp_word_t a, input fp_word_t b);
      return (a > b) ? a - b : b - a;
   endfunction

   task automatic push_expected(input fp_word_t w, input logic exc, input logic exact);
      want_y_q.push_back(w);
      want_exc_q.push_back(exc);
      exact_q.push_back(exact);
   endtask

   task automatic queue_expected(input fp_word_t w);
      if ((w[30:23] == 8'hff) && (w[22:0] != 23'd0))
         push_expected({w[31], 8'hff, 1'b1, w[21:0]}, 1'b1, 1'b1);
      else if (w == 32'h7f80_0000 || w[30:0] == 31'd0)
         push_expected(w, 1'b0, 1'b1);
      else if (w[31])
         push_expected(32'hffc0_0000, 1'b1, 1'b1);
      else
         push_expected(round_to_single($sqrt(to_real(w))), 1'b0, 1'b0);
   endtask

   task automatic send(input fp_word_t w);
      @(posedge clk);
      #10;
      x = w;
      in_valid = 1'b1;
      queue_expected(w);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #10;
         in_valid = 1'b0;
      end
   endtask

   task automatic drain;
      int n;
      n = 0;
      while (want_y_q.size() != 0 && n < 50) begin
         @(posedge clk);
         n++;
      end
      if (want_y_q.size() != 0) begin
         $display("ERROR at %0t: %0d results never came out", $time, want_y_q.size());
         other_errors++;
      end
   endtask

   // outputs settle after the rising edge
   always @(negedge clk) begin
      if (!reset && out_valid) begin
         if (want_y_q.size() == 0) begin
            $display("ERROR at %0t: result came out with no operand pending", $time);
            other_errors++;
         end else begin
            want_y     = want_y_q.pop_front();
            want_exc   = want_exc_q.pop_front();
            want_exact = exact_q.pop_front();
            checked++;
            assert (exception === want_exc) else begin
               $display("MISMATCH at %0t: exception expected %0b, got %0b",
                        $time, want_exc, exception);
               mismatches++;
            end
            if (want_exact) begin
               assert (y === want_y) else begin
                  $display("MISMATCH at %0t: y expected %h, got %h", $time, want_y, y);
                  mismatches++;
               end
            end else begin
               assert (ulp_gap(y, want_y) <= 32'd2) else begin
                  $display("MISMATCH at %0t: y expected %h within 2 ulp, got %h",
                           $time, want_y, y);
                  mismatches++;
               end
            end
         end
      end
   end

   initial begin
      logic [7:0] e;
      logic [22:0] m;
      lfsr_state   = 16'd57093;
      mismatches   = 0;
      other_errors = 0;
      checked      = 0;
      reset        = 1'b1;
      x            = '0;
      in_valid     = 1'b0;
      repeat (8) @(posedge clk);
      #10;
      reset = 1'b0;
      idle(12);   // out_valid has to stay low here

      // zeros, infinities, NaNs, negatives, then 1.0 and 4.0
      send(32'h0000_0000);
      send(32'h8000_0000);
      send(32'h7f80_0000);
      send(32'hff80_0000);
      send(32'h7fc1_2345);
      send(32'h7f80_0001);
      send(32'hff81_2345);
      send(32'hc080_0000);
      send(32'h8000_0010);
      send(32'h3f80_0000);
      send(32'h4080_0000);
      idle(3);

      send(32'h0000_0001);   // smallest denormal
      send(32'h007f_ffff);
      send(32'h0040_0000);
      for (int i = 0; i < 40; i++) begin
         m = 23'(take_bits(23));
         send({9'b0, (m == 23'd0) ? 23'd1 : m});
      end
      idle(2);

      // bursts of normals with short random gaps
      for (int b = 0; b < 15; b++) begin
         for (int i = 0; i < 20; i++) begin
            e = 8'(take_bits(8));
            if (e == 8'd0)
               e = 8'd1;
            if (e == 8'd255)
               e = 8'd254;
            send({1'b0, e, 23'(take_bits(23))});
         end
         idle(int'(take_bits(2)));
      end
      idle(1);
      drain();

      $display("errors: %0d mismatches, %0d other failures, %0d results checked",
               mismatches, other_errors, checked);
      if (mismatches == 0 && other_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: project.f
+incdir+include
src/fsqrt_pkg.sv
src/sqrt_normalize.sv
src/rsqrt_seed.sv
src/newton_step.sv
src/root_round.sv
src/fp_mul.sv
src/result_select.sv
src/fsqrt.sv
bench/fsqrt_props.sv
bench/fsqrt_tb.sv

// File: Makefile
TOP = fsqrt_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log || ! grep -q "SIMULATION PASSED" sim.log; then \
		echo "sim: failure found in sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
